//--- rtl/ula_timing_pkg.sv
package ula_timing_pkg;

	typedef enum logic {
		mode_pentagon = 1'b0,
		mode_128      = 1'b1
	} timing_mode_e;

	localparam int h_area = 256;
	localparam int v_area = 192;

	localparam int h_total_pent = 448;
	localparam int v_total_pent = 320;
	localparam int h_total_128  = 456;
	localparam int v_total_128  = 311;

	// sync windows, end is exclusive
	localparam int hsync_from_pent = h_area + 64;
	localparam int hsync_to_pent   = hsync_from_pent + 33;
	localparam int vsync_from_pent = v_area + 56;
	localparam int vsync_to_pent   = vsync_from_pent + 8;
	localparam int hsync_from_128  = h_area + 76;
	localparam int hsync_to_128    = hsync_from_128 + 33;
	localparam int vsync_from_128  = v_area + 47;
	localparam int vsync_to_128    = vsync_from_128 + 8;

	localparam int int_v_pent      = 239;
	localparam int int_h_from_pent = 316;
	localparam int int_h_to_pent   = 384;
	localparam int int_v_128       = 248;
	localparam int int_h_from_128  = 0;
	localparam int int_h_to_128    = 64;

	localparam int hc_w  = 9;
	localparam int vc_w  = 9;
	localparam int sub_w = 2; // 4 clk28 per pixel

endpackage

//--- rtl/ula_io_pkg.sv
package ula_io_pkg;

	typedef enum logic [1:0] {
		sel_none = 2'd0,
		sel_fe   = 2'd1,
		sel_7ffd = 2'd2
	} port_sel_e;

	// full port addresses
	localparam logic [15:0] port_fe_addr   = 16'h00fe;
	localparam logic [15:0] port_7ffd_addr = 16'h7ffd;

	// address lines actually decoded
	localparam logic [15:0] port_fe_mask   = 16'h0001;
	localparam logic [15:0] port_7ffd_mask = 16'h8002;

	localparam int ram_page_w = 3;

	localparam int page_screen_lo = 5; // #4000..#7fff
	localparam int page_screen_hi = 2; // #8000..#bfff

	// #7ffd layout
	localparam int lock_bit = 5;
	localparam int rom_bit  = 4;

	localparam int border_w = 3;

endpackage

//--- rtl/frame_timer.sv
`timescale 1ns/1ps

module frame_timer (
	input  logic clk28,
	input  logic rst_n,
	input  ula_timing_pkg::timing_mode_e timing_128,
	output logic n_int,
	output logic hsync,
	output logic vsync
);
	import ula_timing_pkg::*;

	logic [sub_w-1:0] sub;
	logic [hc_w-1:0] hc;
	logic [vc_w-1:0] vc;
	logic [hc_w-1:0] h_last;
	logic [vc_w-1:0] v_last;
	logic is_128;
	logic pix_end;
	logic line_end;
	logic hsync_next;
	logic vsync_next;
	logic int_next;

	assign is_128 = (timing_128 == mode_128);
	assign h_last = is_128 ? hc_w'(h_total_128 - 1) : hc_w'(h_total_pent - 1);
	assign v_last = is_128 ? vc_w'(v_total_128 - 1) : vc_w'(v_total_pent - 1);

	assign pix_end  = (sub == {sub_w{1'b1}});
	assign line_end = pix_end && (hc >= h_last); // >= covers a mode switch mid-line

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			sub <= '0;
			hc <= '0;
			vc <= '0;
		end else begin
			sub <= sub + 1'b1;
			if (line_end) begin
				hc <= '0;
				if (vc >= v_last)
					vc <= '0;
				else
					vc <= vc + 1'b1;
			end else if (pix_end) begin
				hc <= hc + 1'b1;
			end
		end
	end

	always_comb begin
		if (is_128) begin
			hsync_next = (hc >= hsync_from_128) && (hc < hsync_to_128);
			vsync_next = (vc >= vsync_from_128) && (vc < vsync_to_128);
			int_next = (vc == int_v_128) && (hc >= int_h_from_128) && (hc < int_h_to_128);
		end else begin
			hsync_next = (hc >= hsync_from_pent) && (hc < hsync_to_pent);
			vsync_next = (vc >= vsync_from_pent) && (vc < vsync_to_pent);
			int_next = (vc == int_v_pent) && (hc >= int_h_from_pent) && (hc < int_h_to_pent);
		end
	end

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			n_int <= 1'b1;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			n_int <= ~int_next; // one frame interrupt per field
			hsync <= hsync_next;
			vsync <= vsync_next;
		end
	end

endmodule

//--- rtl/port_decoder.sv
`timescale 1ns/1ps

module port_decoder (
	input  logic [15:0] xa,
	input  logic n_iorq,
	input  logic n_m1,
	input  logic n_rd,
	input  logic n_wr,
	output ula_io_pkg::port_sel_e sel,
	output logic io_rd,
	output logic io_wr
);
	import ula_io_pkg::*;

	logic io_cycle;
	logic hit_fe;
	logic hit_7ffd;

	// m1 low with iorq is an interrupt ack, not a port access
	assign io_cycle = !n_iorq && n_m1;

	// partial decode, only the masked lines matter
	assign hit_fe   = (xa & port_fe_mask) == (port_fe_addr & port_fe_mask);
	assign hit_7ffd = (xa & port_7ffd_mask) == (port_7ffd_addr & port_7ffd_mask);

	always_comb begin
		sel = sel_none;
		if (io_cycle) begin
			if (hit_fe)
				sel = sel_fe; // #fe wins on overlap
			else if (hit_7ffd)
				sel = sel_7ffd;
		end
	end

	assign io_rd = io_cycle && !n_rd;
	assign io_wr = io_cycle && !n_wr;

endmodule

//--- rtl/port_registers.sv
`timescale 1ns/1ps

module port_registers (
	input  logic clk28,
	input  logic rst_n,
	input  ula_io_pkg::port_sel_e sel,
	input  logic io_wr,
	input  logic [7:0] xd_in,
	output logic [ula_io_pkg::border_w-1:0] border,
	output logic beeper,
	output logic tape_out,
	output logic [ula_io_pkg::ram_page_w-1:0] ram_bank,
	output logic rom_bank
);
	import ula_io_pkg::*;

	logic fe_wr;
	logic p7ffd_wr;
	logic lock;

	assign fe_wr    = io_wr && (sel == sel_fe);
	assign p7ffd_wr = io_wr && (sel == sel_7ffd) && !lock;

	// #fe: speaker, tape and border
	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			border <= '0;
			beeper <= 1'b0;
			tape_out <= 1'b0;
		end else if (fe_wr) begin
			beeper <= xd_in[4];
			tape_out <= xd_in[3];
			border <= xd_in[border_w-1:0];
		end
	end

	// #7ffd paging
	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			ram_bank <= '0;
			rom_bank <= 1'b0;
		end else if (p7ffd_wr) begin
			ram_bank <= xd_in[ram_page_w-1:0];
			rom_bank <= xd_in[rom_bit];
		end
	end

	// sticky until reset
	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n)
			lock <= 1'b0;
		else if (p7ffd_wr && xd_in[lock_bit])
			lock <= 1'b1;
	end

endmodule

//--- rtl/memory_mapper.sv
`timescale 1ns/1ps

module memory_mapper (
	input  logic clk28,
	input  logic rst_n,
	input  logic [15:0] xa,
	input  logic n_mreq,
	input  logic n_rfsh,
	input  logic n_rd,
	input  ula_io_pkg::port_sel_e sel,
	input  logic io_rd,
	input  logic [4:0] kd,
	input  logic tape_in,
	input  logic [ula_io_pkg::ram_page_w-1:0] ram_bank,
	input  logic rom_bank,
	output logic n_romcs,
	output logic n_ramcs,
	output logic [ula_io_pkg::ram_page_w-1:0] ram_page,
	output logic rom_page,
	output logic [7:0] xd_out,
	output logic xd_oe
);
	import ula_io_pkg::*;

	logic mem_cycle;
	logic rom_area;
	logic fe_rd;
	logic [ram_page_w-1:0] page_next;

	assign mem_cycle = !n_mreq && n_rfsh; // refresh never selects a chip
	assign rom_area  = (xa[15:14] == 2'b00);
	assign fe_rd     = io_rd && !n_rd && (sel == sel_fe);

	always_comb begin
		case (xa[15:14])
			2'b01: page_next = ram_page_w'(page_screen_lo);
			2'b10: page_next = ram_page_w'(page_screen_hi);
			default: page_next = ram_bank;
		endcase
	end

	always_ff @(posedge clk28 or negedge rst_n) begin
		if (!rst_n) begin
			n_romcs <= 1'b1;
			n_ramcs <= 1'b1;
			xd_oe <= 1'b0;
		end else begin
			n_romcs <= !(mem_cycle && rom_area);
			n_ramcs <= !(mem_cycle && !rom_area);
			xd_oe <= fe_rd; // #7ffd reads stay off the bus
		end
	end

	always_ff @(posedge clk28) begin
		ram_page <= page_next;
		if (fe_rd)
			xd_out <= {1'b1, tape_in, 1'b1, kd};
	end

	assign rom_page = rom_bank;

endmodule

//--- rtl/zx_ula_core.sv
`timescale 1ns/1ps

module zx_ula_core (
	input  logic clk28,
	input  logic rst_n,

	input  logic [15:0] xa,
	input  logic [7:0] xd_in,
	input  logic n_rd,
	input  logic n_wr,
	input  logic n_mreq,
	input  logic n_iorq,
	input  logic n_m1,
	input  logic n_rfsh,

	input  logic [4:0] kd,
	input  logic tape_in,
	input  ula_timing_pkg::timing_mode_e timing_128,

	output logic [7:0] xd_out,
	output logic xd_oe,

	output logic n_romcs,
	output logic n_ramcs,
	output logic rom_page,
	output logic [ula_io_pkg::ram_page_w-1:0] ram_page,

	output logic [ula_io_pkg::border_w-1:0] border,
	output logic beeper,
	output logic tape_out,

	output logic n_int,
	output logic hsync,
	output logic vsync
);
	import ula_io_pkg::*;

	port_sel_e sel;
	logic io_rd;
	logic io_wr;
	logic [ram_page_w-1:0] ram_bank;
	logic rom_bank;

	frame_timer frame_timer_i (
		.clk28      (clk28),
		.rst_n      (rst_n),
		.timing_128 (timing_128),
		.n_int      (n_int),
		.hsync      (hsync),
		.vsync      (vsync)
	);

	port_decoder port_decoder_i (
		.xa     (xa),
		.n_iorq (n_iorq),
		.n_m1   (n_m1),
		.n_rd   (n_rd),
		.n_wr   (n_wr),
		.sel    (sel),
		.io_rd  (io_rd),
		.io_wr  (io_wr)
	);

	port_registers port_registers_i (
		.clk28    (clk28),
		.rst_n    (rst_n),
		.sel      (sel),
		.io_wr    (io_wr),
		.xd_in    (xd_in),
		.border   (border),
		.beeper   (beeper),
		.tape_out (tape_out),
		.ram_bank (ram_bank),
		.rom_bank (rom_bank)
	);

	memory_mapper memory_mapper_i (
		.clk28    (clk28),
		.rst_n    (rst_n),
		.xa       (xa),
		.n_mreq   (n_mreq),
		.n_rfsh   (n_rfsh),
		.n_rd     (n_rd),
		.sel      (sel),
		.io_rd    (io_rd),
		.kd       (kd),
		.tape_in  (tape_in),
		.ram_bank (ram_bank),
		.rom_bank (rom_bank),
		.n_romcs  (n_romcs),
		.n_ramcs  (n_ramcs),
		.ram_page (ram_page),
		.rom_page (rom_page),
		.xd_out   (xd_out),
		.xd_oe    (xd_oe)
	);

endmodule

//--- tb/zx_ula_properties.sv
`timescale 1ns/1ps

module zx_ula_properties (
	input logic clk28,
	input logic rst_n,
	input logic [15:0] xa,
	input logic n_mreq,
	input logic n_rfsh,
	input logic n_rd,
	input logic xd_oe,
	input logic n_romcs,
	input logic n_ramcs,
	input logic [ula_io_pkg::ram_page_w-1:0] ram_bank,
	input logic lock,
	input logic n_int
);

	// bus driven only around a cpu read
	oe_needs_rd: assert property (@(posedge clk28) disable iff (!rst_n)
		(n_rd && $past(n_rd)) |-> !xd_oe)
		else $error("xd_oe high after n_rd was released for two cycles");

	// each select needs a memory cycle in its own window, so never both low
	rom_cs_decode: assert property (@(posedge clk28) disable iff (!rst_n)
		!n_romcs |-> $past(!n_mreq && n_rfsh && (xa[15:14] == 2'b00)))
		else $error("n_romcs low without a rom memory cycle before it");

	ram_cs_decode: assert property (@(posedge clk28) disable iff (!rst_n)
		!n_ramcs |-> $past(!n_mreq && n_rfsh && (xa[15:14] != 2'b00)))
		else $error("n_ramcs low without a ram memory cycle before it");

	bank_frozen_by_lock: assert property (@(posedge clk28) disable iff (!rst_n)
		$past(lock) |-> $stable(ram_bank))
		else $error("ram_bank changed while #7ffd was locked");

	int_idle_in_reset: assert property (@(posedge clk28) !rst_n |-> n_int)
		else $error("n_int low during reset");

endmodule

//--- tb/tb_zx_ula_core.sv
`timescale 1ns/1ps

module tb_zx_ula_core;
	import ula_timing_pkg::*;
	import ula_io_pkg::*;

	// two pentagon frames, one 128k frame, plus the bus tests
	localparam int timeout_cycles =
		4 * (2 * h_total_pent * v_total_pent + h_total_128 * v_total_128) + 20000;

	logic clk28;
	logic rst_n;
	logic [15:0] xa;
	logic [7:0] xd_in;
	logic n_rd;
	logic n_wr;
	logic n_mreq;
	logic n_iorq;
	logic n_m1;
	logic n_rfsh;
	logic [4:0] kd;
	logic tape_in;
	timing_mode_e timing_128;
	logic [7:0] xd_out;
	logic xd_oe;
	logic n_romcs;
	logic n_ramcs;
	logic rom_page;
	logic [ram_page_w-1:0] ram_page;
	logic [border_w-1:0] border;
	logic beeper;
	logic tape_out;
	logic n_int;
	logic hsync;
	logic vsync;

	int cycle_count = 0;
	logic [31:0] lfsr_state = 32'h5a0c_9cfd;

	zx_ula_core zx_ula_core_i (.*);

	bind zx_ula_core zx_ula_properties zx_ula_properties_i (
		.clk28    (clk28),
		.rst_n    (rst_n),
		.xa       (xa),
		.n_mreq   (n_mreq),
		.n_rfsh   (n_rfsh),
		.n_rd     (n_rd),
		.xd_oe    (xd_oe),
		.n_romcs  (n_romcs),
		.n_ramcs  (n_ramcs),
		.ram_bank (ram_bank),
		.lock     (port_registers_i.lock),
		.n_int    (n_int)
	);

	initial begin
		clk28 = 1'b0;
		forever #5 clk28 = ~clk28;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1);
	endtask

	always @(posedge clk28) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			abort_run($sformatf("timeout, run still going after %0d cycles", timeout_cycles));
	end

	// taps 32 22 2 1
	function automatic logic [7:0] random_bits(input int n);
		logic [7:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[6:0], fb};
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected)
			abort_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected));
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk28);
		xa <= addr;
		xd_in <= data;
		n_iorq <= 1'b0;
		n_wr <= 1'b0;
		repeat (3) @(posedge clk28);
		n_iorq <= 1'b1;
		n_wr <= 1'b1;
		@(negedge clk28);
	endtask

	task automatic wait_oe(input logic level);
		int n;
		n = 0;
		@(negedge clk28);
		while (xd_oe !== level) begin
			n++;
			if (n > 8)
				abort_run($sformatf("xd_oe did not go to %0b within 8 cycles", level));
			@(negedge clk28);
		end
	endtask

	task automatic mem_check(input logic [15:0] addr, input logic rom, input logic [2:0] page);
		@(posedge clk28);
		xa <= addr;
		n_mreq <= 1'b0;
		n_rd <= 1'b0;
		@(posedge clk28); // chip selects are one cycle late
		@(negedge clk28);
		check("n_romcs", n_romcs, !rom);
		check("n_ramcs", n_ramcs, rom);
		if (!rom)
			check("ram_page", ram_page, page);
		@(posedge clk28);
		n_mreq <= 1'b1;
		n_rd <= 1'b1;
	endtask

	task automatic reset_state();
		@(negedge clk28);
		check("n_int", n_int, 1'b1);
		check("n_romcs", n_romcs, 1'b1);
		check("n_ramcs", n_ramcs, 1'b1);
		check("xd_oe", xd_oe, 1'b0);
		check("border", border, 3'd0);
		check("beeper", beeper, 1'b0);
		check("tape_out", tape_out, 1'b0);
	endtask

	task automatic fe_write_read();
		logic [7:0] data;
		logic [4:0] keys;
		logic tin;
		for (int i = 0; i < 4; i++) begin
			data = random_bits(8);
			io_write({random_bits(8), 8'hfe}, data); // only xa[0] decoded
			check("border", border, data[2:0]);
			check("beeper", beeper, data[4]);
			check("tape_out", tape_out, data[3]);
		end
		for (int i = 0; i < 4; i++) begin
			keys = 5'(random_bits(5));
			tin = 1'(random_bits(1));
			@(posedge clk28);
			xa <= port_fe_addr;
			kd <= keys;
			tape_in <= tin;
			n_iorq <= 1'b0;
			n_rd <= 1'b0;
			wait_oe(1'b1);
			check("xd_out", xd_out, {1'b1, tin, 1'b1, keys});
			@(posedge clk28);
			n_iorq <= 1'b1;
			n_rd <= 1'b1;
			wait_oe(1'b0);
		end
	endtask

	task automatic bank_paging();
		logic [7:0] data;
		for (int i = 0; i < 4; i++) begin
			data = random_bits(8) & 8'hdf; // lock stays clear
			io_write(port_7ffd_addr, data);
			check("rom_page", rom_page, data[4]);
			mem_check({2'b11, 6'h00, random_bits(8)}, 1'b0, data[2:0]);
			mem_check({2'b01, 6'h00, random_bits(8)}, 1'b0, 3'd5);
			mem_check({2'b10, 6'h00, random_bits(8)}, 1'b0, 3'd2);
			mem_check({2'b00, 6'h00, random_bits(8)}, 1'b1, 3'd0);
		end
	endtask

	task automatic lock_7ffd();
		logic [7:0] data;
		data = random_bits(8) | 8'h20;
		io_write(port_7ffd_addr, data);
		io_write(port_7ffd_addr, data ^ 8'h17);
		check("rom_page", rom_page, data[4]);
		mem_check(16'hc000, 1'b0, data[2:0]);
	endtask

	task automatic int_measure(input timing_mode_e mode, input int width, input int period,
		input int hs_width, input int line_period, input int vs_width);
		int t_fall;
		int t_edge;
		@(posedge clk28);
		timing_128 <= mode;
		@(negedge clk28);
		while (n_int !== 1'b1) @(negedge clk28);
		while (n_int !== 1'b0) @(negedge clk28);
		t_fall = cycle_count;
		while (n_int !== 1'b1) @(negedge clk28);
		check("n_int low width", cycle_count - t_fall, width);
		// next hsync pulse, then the one after it
		while (hsync !== 1'b0) @(negedge clk28);
		while (hsync !== 1'b1) @(negedge clk28);
		t_edge = cycle_count;
		while (hsync !== 1'b0) @(negedge clk28);
		check("hsync width", cycle_count - t_edge, hs_width);
		while (hsync !== 1'b1) @(negedge clk28);
		check("hsync period", cycle_count - t_edge, line_period);
		while (vsync !== 1'b1) @(negedge clk28); // vsync lies between two interrupts
		t_edge = cycle_count;
		while (vsync !== 1'b0) @(negedge clk28);
		check("vsync width", cycle_count - t_edge, vs_width);
		while (n_int !== 1'b0) @(negedge clk28);
		check("n_int period", cycle_count - t_fall, period);
	endtask

	task automatic int_pentagon();
		int_measure(mode_pentagon, 4 * (int_h_to_pent - int_h_from_pent),
			4 * h_total_pent * v_total_pent,
			4 * (hsync_to_pent - hsync_from_pent), 4 * h_total_pent,
			4 * h_total_pent * (vsync_to_pent - vsync_from_pent));
	endtask

	task automatic int_128();
		int_measure(mode_128, 4 * (int_h_to_128 - int_h_from_128),
			4 * h_total_128 * v_total_128,
			4 * (hsync_to_128 - hsync_from_128), 4 * h_total_128,
			4 * h_total_128 * (vsync_to_128 - vsync_from_128));
	endtask

	initial begin
		rst_n = 1'b1;
		xa = '0;
		xd_in = '0;
		n_rd = 1'b1;
		n_wr = 1'b1;
		n_mreq = 1'b1;
		n_iorq = 1'b1;
		n_m1 = 1'b1;
		n_rfsh = 1'b1;
		kd = 5'h1f;
		tape_in = 1'b0;
		timing_128 = mode_pentagon;
		#1 rst_n = 1'b0;
		repeat (8) @(posedge clk28);
		rst_n <= 1'b1;
		reset_state();
		fe_write_read();
		bank_paging();
		lock_7ffd();
		int_pentagon();
		int_128();
		$display("Test OK");
		$finish;
	end

endmodule

//--- zx_ula_core.f
rtl/ula_timing_pkg.sv
rtl/ula_io_pkg.sv
rtl/frame_timer.sv
rtl/port_decoder.sv
rtl/port_registers.sv
rtl/memory_mapper.sv
rtl/zx_ula_core.sv
tb/zx_ula_properties.sv
tb/tb_zx_ula_core.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_zx_ula_core \
		-f zx_ula_core.f -Mdir obj_dir -o tb_zx_ula_core
	./obj_dir/tb_zx_ula_core | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
